// ==== icache_tag_top.f ====
+incdir+common
common/icache_tag_pkg.sv
src/sram_model.sv
icache_tag/icache_tag_par_ram.sv
icache_tag/icache_tag_lookup.sv
src/icache_tag_top.sv
testbench/icache_tag_assertions.sv
testbench/icache_tag_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= icache_tag_tb
FILELIST  ?= icache_tag_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
EXTRA     ?=

SOURCES := $(wildcard common/* src/* icache_tag/* testbench/*)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/icache_tag_tb.sv ====
// directed testbench for the tag subsystem with scoreboard, LCG and compare tasks
`include "icache_tag_defs.svh"

module icache_tag_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import icache_tag_pkg::*;

	logic        clk;
	logic        arst_n;
	logic        lookup_valid;
	lookup_req_t lookup_req;
	logic        fill_valid;
	fill_req_t   fill_req;
	logic        diag_valid;
	diag_req_t   diag_req;
	logic        rsp_valid;
	lookup_rsp_t rsp;

	tag_word_t   sb_word [`ICACHE_TAG_WAYS][2**`ICACHE_TAG_AW];	// expected RAM contents
	logic        sb_repl [2**`ICACHE_TAG_AW];
	logic [31:0] lcg_state;
	int          rsp_errs;
	int          mask_errs;
	int          misc_errs;
	idx_t        used_idx [6];
	tag_t        used_tag [6];

	icache_tag_top UUT (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	//////////////////////////////////////////////////
	// models
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic par_t check_bits(input tag_entry_t e);
		logic [$bits(tag_entry_t)-1:0] b;
		logic [$bits(tag_entry_t)-1:0] m;
		par_t p;
		b = e;
		for (int i = 0; i < `ICACHE_TAG_PW; i++) begin
			m = 15'h1111 << i;	// every fourth payload bit
			p[i] = ^(b & m);
		end
		return p;
	endfunction

	function automatic tag_word_t good_word(input logic v, input logic lk, input tag_t t);
		tag_word_t w;
		w.entry.valid = v;
		w.entry.lock = lk;
		w.entry.lock_dup = lk;
		w.entry.tag = t;
		w.par = check_bits(w.entry);
		return w;
	endfunction

	function automatic lookup_rsp_t predict(input idx_t idx, input tag_t t);
		lookup_rsp_t r;
		tag_word_t   w;
		logic [1:0]  err;
		logic [1:0]  hit;
		logic        rp;
		for (int k = 0; k < 2; k++) begin
			w = sb_word[k][idx];
			err[k] = (check_bits(w.entry) != w.par) || (w.entry.lock != w.entry.lock_dup);
			hit[k] = w.entry.valid && (w.entry.tag == t) && !err[k];
		end
		rp = sb_repl[idx];
		r.hit = |hit;
		r.hit_way = way_t'(!hit[0] && hit[1]);
		r.par_err = |err;
		r.err_way_mask = err;
		r.victim_valid = 1'b1;
		if (!sb_word[0][idx].entry.valid) r.victim_way = 1'b0;
		else if (!sb_word[1][idx].entry.valid) r.victim_way = 1'b1;
		else if (!sb_word[rp][idx].entry.lock) r.victim_way = rp;
		else if (!sb_word[!rp][idx].entry.lock) r.victim_way = !rp;
		else begin
			r.victim_valid = 1'b0;
			r.victim_way = rp;
		end
		return r;
	endfunction

	task automatic check_rsp(input string name, input lookup_rsp_t exp, input lookup_rsp_t act);
		lookup_rsp_t e;
		e = exp;
		if (!e.victim_valid) e.victim_way = act.victim_way;	// don't care when set is locked
		if (act !== e) begin
			rsp_errs++;
			$display("FAIL %s: expected %h actual %h", name, e, act);
		end
	endtask

	task automatic check_mask(input string name, input logic [`ICACHE_TAG_WAYS-1:0] exp,
			input logic [`ICACHE_TAG_WAYS-1:0] act);
		if (act !== exp) begin
			mask_errs++;
			$display("FAIL %s: expected mask %b actual mask %b", name, exp, act);
		end
	endtask

	//////////////////////////////////////////////////
	// drivers
	//////////////////////////////////////////////////

	task automatic fill_way(input idx_t idx, input way_t way, input tag_t t, input logic lk);
		@(negedge clk);
		fill_valid = 1'b1;
		fill_req = '{index: idx, way: way, lock: lk, tag: t};
		@(negedge clk);
		fill_valid = 1'b0;
		sb_word[way][idx] = good_word(1'b1, lk, t);
		sb_repl[idx] = ~way;
	endtask

	task automatic diag_write(input idx_t idx, input way_t way, input tag_word_t w);
		@(negedge clk);
		diag_valid = 1'b1;
		diag_req = '{index: idx, way: way, word: w};
		@(negedge clk);
		diag_valid = 1'b0;
		sb_word[way][idx] = w;
		sb_repl[idx] = 1'b0;
	endtask

	task automatic init_set(input idx_t idx);
		diag_write(idx, 1'b0, '0);	// all-zero word has even parity
		diag_write(idx, 1'b1, '0);
	endtask

	task automatic lookup_check(input string name, input idx_t idx, input tag_t t,
			output lookup_rsp_t got);
		lookup_rsp_t exp;
		int          n;
		exp = predict(idx, t);
		@(negedge clk);
		lookup_valid = 1'b1;
		lookup_req = '{index: idx, tag: t};
		@(negedge clk);
		lookup_valid = 1'b0;
		n = 0;
		while (!rsp_valid && n < 8) begin
			@(negedge clk);
			n++;
		end
		got = rsp;
		if (!rsp_valid) begin
			misc_errs++;
			$display("%s: no lookup response within 8 cycles", name);
		end else check_rsp(name, exp, rsp);
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic reset_test();
		idx_t        idx;
		lookup_rsp_t got;
		for (int c = 0; c < 4; c++) begin
			@(negedge clk);
			if (rsp_valid !== 1'b0) begin
				misc_errs++;
				$display("reset_test: rsp_valid high with no lookup after reset");
			end
		end
		for (int k = 0; k < 3; k++) begin
			idx = idx_t'(next_rand() >> 23);
			init_set(idx);
			lookup_check("reset_miss", idx, tag_t'(next_rand() >> 20), got);
		end
	endtask

	task automatic fill_hit_test();
		logic [31:0] r;
		lookup_rsp_t got;
		for (int k = 0; k < 6; k++) begin
			used_idx[k] = idx_t'(next_rand() >> 23);
			r = next_rand();
			used_tag[k] = tag_t'(r >> 20);
			init_set(used_idx[k]);
			fill_way(used_idx[k], way_t'(r >> 19), used_tag[k], 1'b0);
			lookup_check("fill_hit", used_idx[k], used_tag[k], got);
			lookup_check("fill_miss", used_idx[k], used_tag[k] ^ tag_t'(1), got);
		end
	endtask

	task automatic round_robin_test();
		idx_t        idx;
		tag_t        t;
		lookup_rsp_t got;
		idx = idx_t'(next_rand() >> 23);
		init_set(idx);
		for (int k = 0; k < 5; k++) begin
			t = tag_t'(next_rand() >> 20);
			fill_way(idx, way_t'(k % 2), t, 1'b0);	// last fill sets the pointer
			lookup_check("round_robin", idx, t, got);
		end
	endtask

	task automatic lock_test();
		idx_t        idx;
		tag_t        ta;
		tag_t        tb;
		lookup_rsp_t got;
		idx = idx_t'(next_rand() >> 23);
		ta = tag_t'(next_rand() >> 20);
		tb = ta ^ tag_t'(12'h5a5);
		init_set(idx);
		fill_way(idx, 1'b0, ta, 1'b1);
		fill_way(idx, 1'b1, tb, 1'b0);
		lookup_check("lock_skip", idx, ta, got);
		fill_way(idx, 1'b1, tb, 1'b1);
		lookup_check("lock_all", idx, tb, got);
	endtask

	task automatic parity_test();
		idx_t        idx;
		way_t        fw;
		tag_word_t   w;
		lookup_rsp_t got;
		logic [`ICACHE_TAG_WAYS-1:0] exp_mask;
		for (int k = 0; k < 3; k++) begin
			idx = idx_t'(next_rand() >> 23);
			fw = way_t'(k % 2);
			w = good_word(1'b1, 1'b0, tag_t'(next_rand() >> 20));
			case (k)
				0: w.par[0] = ~w.par[0];
				1: w.entry.tag[5] = ~w.entry.tag[5];	// stale check bits
				default: begin
					w.entry.lock_dup = 1'b1;
					w.par = check_bits(w.entry);
				end
			endcase
			init_set(idx);
			diag_write(idx, fw, w);
			fill_way(idx, ~fw, w.entry.tag ^ tag_t'(1), 1'b0);	// clean way, neighbor tag
			exp_mask = '0;
			exp_mask[fw] = 1'b1;
			lookup_check("parity_bad", idx, w.entry.tag, got);
			check_mask("parity_bad", exp_mask, got.err_way_mask);
			lookup_check("parity_good", idx, w.entry.tag ^ tag_t'(1), got);
			check_mask("parity_good", exp_mask, got.err_way_mask);
		end
	endtask

	task automatic back_to_back_test();
		lookup_rsp_t exp [6];
		for (int k = 0; k <= 6; k++) begin
			@(negedge clk);
			if (k > 0 && rsp_valid !== 1'b1) begin
				misc_errs++;
				$display("back_to_back: response %0d missing one cycle after its lookup", k - 1);
			end else if (k > 0) check_rsp("back_to_back", exp[k-1], rsp);
			if (k < 6) begin
				exp[k] = predict(used_idx[k], used_tag[k]);
				lookup_valid = 1'b1;
				lookup_req = '{index: used_idx[k], tag: used_tag[k]};
			end else lookup_valid = 1'b0;
		end
	endtask

	initial begin
		lcg_state = 32'h8c05_7d94;
		rsp_errs = 0;
		mask_errs = 0;
		misc_errs = 0;
		arst_n = 1'b0;
		lookup_valid = 1'b0;
		lookup_req = '0;
		fill_valid = 1'b0;
		fill_req = '0;
		diag_valid = 1'b0;
		diag_req = '0;
		repeat (16) begin
			@(negedge clk);
			if (rsp_valid !== 1'b0) begin
				misc_errs++;
				$display("rsp_valid not low during reset");
			end
		end
		arst_n = 1'b1;
		reset_test();
		fill_hit_test();
		round_robin_test();
		lock_test();
		parity_test();
		back_to_back_test();
		$display("errors: response %0d, mask %0d, other %0d", rsp_errs, mask_errs, misc_errs);
		if (rsp_errs + mask_errs + misc_errs == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== testbench/icache_tag_assertions.sv ====
// bound checks for request exclusivity and lookup response timing
module icache_tag_assertions (
	input logic clk,
	input logic arst_n,
	input logic lookup_valid,
	input logic fill_valid,
	input logic diag_valid,
	input logic rsp_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	// one request kind per cycle
	a_one_req: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({lookup_valid, fill_valid, diag_valid}))
		else $error("more than one request strobe in a cycle");

	a_rsp_follows: assert property (@(posedge clk) disable iff (!arst_n)
		lookup_valid |=> rsp_valid)
		else $error("lookup without a response one cycle later");

	a_rsp_source: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid |-> $past(lookup_valid))
		else $error("response without a lookup one cycle before");

	a_rsp_reset: assert property (@(posedge clk) !arst_n |-> !rsp_valid)
		else $error("rsp_valid high during reset");

endmodule

bind icache_tag_top icache_tag_assertions u_assertions (.*);

// ==== src/icache_tag_top.sv ====
// tag subsystem top with request decode, two tag ways, replacement RAM and lookup
`include "icache_tag_defs.svh"

module icache_tag_top (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        lookup_valid,
	input  icache_tag_pkg::lookup_req_t lookup_req,
	input  logic                        fill_valid,
	input  icache_tag_pkg::fill_req_t   fill_req,
	input  logic                        diag_valid,
	input  icache_tag_pkg::diag_req_t   diag_req,
	output logic                        rsp_valid,
	output icache_tag_pkg::lookup_rsp_t rsp
);

	import icache_tag_pkg::*;

	idx_t                        ram_addr;
	tag_entry_t                  fill_entry;
	tag_entry_t                  way_entry [`ICACHE_TAG_WAYS];
	logic [`ICACHE_TAG_WAYS-1:0] way_err;
	logic                        repl_cs;
	logic                        repl_we;
	logic                        repl_din;
	logic                        repl_q;

	//////////////////////////////////////////////////
	// request decode
	//////////////////////////////////////////////////

	// strobes are mutually exclusive
	always_comb begin
		if (fill_valid) begin
			ram_addr = fill_req.index;
		end else if (diag_valid) begin
			ram_addr = diag_req.index;
		end else begin
			ram_addr = lookup_req.index;
		end
	end

	always_comb begin
		fill_entry.valid    = 1'b1;
		fill_entry.lock     = fill_req.lock;
		fill_entry.lock_dup = fill_req.lock;
		fill_entry.tag      = fill_req.tag;
	end

	//////////////////////////////////////////////////
	// tag ways
	//////////////////////////////////////////////////

	for (genvar w = 0; w < `ICACHE_TAG_WAYS; w++) begin : g_way
		logic sel_fill;
		logic sel_diag;

		assign sel_fill = fill_valid && (fill_req.way == way_t'(w));
		assign sel_diag = diag_valid && (diag_req.way == way_t'(w));

		icache_tag_par_ram u_par_ram (
			.clk    (clk),
			.cs     (lookup_valid | sel_fill | sel_diag),	// lookup reads every way
			.we     (sel_fill | sel_diag),
			.raw    (diag_valid),
			.addr   (ram_addr),
			.wentry (fill_entry),
			.wraw   (diag_req.word),
			.rentry (way_entry[w]),
			.err    (way_err[w])
		);
	end

	//////////////////////////////////////////////////
	// replacement pointer
	//////////////////////////////////////////////////

	assign repl_cs  = lookup_valid | fill_valid | diag_valid;
	assign repl_we  = fill_valid | diag_valid;
	assign repl_din = fill_valid ? ~fill_req.way[0] : 1'b0;	// point at way not filled

	sram_model #(
		.AW     (`ICACHE_TAG_AW),
		.word_t (logic)
	) u_repl_ram (
		.clk  (clk),
		.cs   (repl_cs),
		.we   (repl_we),
		.addr (ram_addr),
		.din  (repl_din),
		.dout (repl_q)
	);

	icache_tag_lookup u_lookup (
		.clk          (clk),
		.arst_n       (arst_n),
		.lookup_valid (lookup_valid),
		.lookup_tag   (lookup_req.tag),
		.way_entry    (way_entry),
		.way_err      (way_err),
		.repl         (repl_q),
		.rsp_valid    (rsp_valid),
		.rsp          (rsp)
	);

endmodule

// ==== icache_tag/icache_tag_lookup.sv ====
// tag compare, hit and error merging, and victim choice for one lookup
`include "icache_tag_defs.svh"

module icache_tag_lookup (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        lookup_valid,
	input  logic [`ICACHE_TAG_TW-1:0]   lookup_tag,
	input  icache_tag_pkg::tag_entry_t  way_entry [`ICACHE_TAG_WAYS],
	input  logic [`ICACHE_TAG_WAYS-1:0] way_err,
	input  logic                        repl,
	output logic                        rsp_valid,
	output icache_tag_pkg::lookup_rsp_t rsp
);

	import icache_tag_pkg::*;

	tag_t                        tag_q;
	logic [`ICACHE_TAG_WAYS-1:0] way_hit;
	logic                        inv_found;
	way_t                        inv_way;
	way_t                        repl_way;
	way_t                        other_way;

	//////////////////////////////////////////////////
	// request stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= lookup_valid;	// RAM data lands next cycle
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_valid) begin
			tag_q <= lookup_tag;
		end
	end

	//////////////////////////////////////////////////
	// hit and error
	//////////////////////////////////////////////////

	always_comb begin
		for (int w = 0; w < `ICACHE_TAG_WAYS; w++) begin
			way_hit[w] = way_entry[w].valid && (way_entry[w].tag == tag_q) && !way_err[w];
		end
	end

	always_comb begin
		rsp.hit     = |way_hit;
		rsp.hit_way = '0;
		for (int w = `ICACHE_TAG_WAYS - 1; w >= 0; w--) begin
			if (way_hit[w]) begin
				rsp.hit_way = way_t'(w);	// lowest hitting way wins
			end
		end
		rsp.par_err      = |way_err;
		rsp.err_way_mask = way_err;
	end

	//////////////////////////////////////////////////
	// victim
	//////////////////////////////////////////////////

	always_comb begin
		inv_found = 1'b0;
		inv_way   = '0;
		for (int w = `ICACHE_TAG_WAYS - 1; w >= 0; w--) begin
			if (!way_entry[w].valid) begin
				inv_found = 1'b1;
				inv_way   = way_t'(w);
			end
		end
	end

	assign repl_way  = way_t'(repl);
	assign other_way = ~repl_way;

	always_comb begin
		if (inv_found) begin
			rsp.victim_valid = 1'b1;
			rsp.victim_way   = inv_way;
		end else if (!way_entry[repl_way].lock) begin
			rsp.victim_valid = 1'b1;
			rsp.victim_way   = repl_way;
		end else if (!way_entry[other_way].lock) begin
			rsp.victim_valid = 1'b1;
			rsp.victim_way   = other_way;
		end else begin
			rsp.victim_valid = 1'b0;	// whole set locked
			rsp.victim_way   = repl_way;
		end
	end

endmodule

// ==== icache_tag/icache_tag_par_ram.sv ====
// per-way tag RAM wrapper with parity generation and read-side checking
`include "icache_tag_defs.svh"

module icache_tag_par_ram (
	input  logic                      clk,
	input  logic                      cs,
	input  logic                      we,
	input  logic                      raw,
	input  logic [`ICACHE_TAG_AW-1:0] addr,
	input  icache_tag_pkg::tag_entry_t wentry,
	input  icache_tag_pkg::tag_word_t  wraw,
	output icache_tag_pkg::tag_entry_t rentry,
	output logic                      err
);

	import icache_tag_pkg::*;

	tag_word_t wword;
	tag_word_t rword;
	par_t      rpar_calc;
	logic      par_bad;
	logic      lock_bad;

	//////////////////////////////////////////////////
	// write side
	//////////////////////////////////////////////////

	always_comb begin
		if (raw) begin
			wword = wraw;	// diagnostic path, stored as is
		end else begin
			wword.par   = tag_parity(wentry);
			wword.entry = wentry;
		end
	end

	sram_model #(
		.AW     (`ICACHE_TAG_AW),
		.word_t (tag_word_t)
	) u_ram (
		.clk  (clk),
		.cs   (cs),
		.we   (we),
		.addr (addr),
		.din  (wword),
		.dout (rword)
	);

	//////////////////////////////////////////////////
	// read side
	//////////////////////////////////////////////////

	assign rpar_calc = tag_parity(rword.entry);
	assign par_bad   = (rpar_calc != rword.par);
	assign lock_bad  = (rword.entry.lock != rword.entry.lock_dup);

	assign rentry = rword.entry;
	assign err    = par_bad | lock_bad;	// either one disqualifies the way

endmodule

// ==== src/sram_model.sv ====
// single-port synchronous RAM model with a generic word type
module sram_model #(
	parameter int  AW     = 9,
	parameter type word_t = logic
) (
	input  logic          clk,
	input  logic          cs,
	input  logic          we,
	input  logic [AW-1:0] addr,
	input  word_t         din,
	output word_t         dout
);

	localparam int DEPTH = 2 ** AW;

	word_t mem [DEPTH];

	//////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (cs && we) begin
			mem[addr] <= din;
		end
	end

	//////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////

	// holds last read word until the next read
	always_ff @(posedge clk) begin
		if (cs && !we) begin
			dout <= mem[addr];
		end
	end

endmodule

// ==== common/icache_tag_pkg.sv ====
// entry, RAM word, request and response types plus the tag parity function
`include "icache_tag_defs.svh"

package icache_tag_pkg;

	typedef logic [`ICACHE_TAG_AW-1:0] idx_t;
	typedef logic [`ICACHE_TAG_TW-1:0] tag_t;
	typedef logic [`ICACHE_TAG_PW-1:0] par_t;
	typedef logic [$clog2(`ICACHE_TAG_WAYS)-1:0] way_t;

	//////////////////////////////////////////////////
	// stored data
	//////////////////////////////////////////////////

	typedef struct packed {
		logic valid;	// bit 14
		logic lock;	// bit 13
		logic lock_dup;	// bit 12, copy of lock
		tag_t tag;
	} tag_entry_t;

	typedef struct packed {
		par_t       par;	// check bits on top
		tag_entry_t entry;
	} tag_word_t;

	//////////////////////////////////////////////////
	// requests and response
	//////////////////////////////////////////////////

	typedef struct packed {
		idx_t index;
		tag_t tag;
	} lookup_req_t;

	typedef struct packed {
		idx_t index;
		way_t way;
		logic lock;
		tag_t tag;	// valid is implied
	} fill_req_t;

	typedef struct packed {
		idx_t      index;
		way_t      way;
		tag_word_t word;	// raw, check bits included
	} diag_req_t;

	typedef struct packed {
		logic                        hit;
		way_t                        hit_way;
		logic                        par_err;
		logic [`ICACHE_TAG_WAYS-1:0] err_way_mask;
		logic                        victim_valid;
		way_t                        victim_way;
	} lookup_rsp_t;

	// check bit i covers payload bits with index mod PW == i
	function automatic par_t tag_parity(input tag_entry_t e);
		logic [$bits(tag_entry_t)-1:0] bits;
		par_t p;
		bits = e;
		p = '0;
		for (int i = 0; i < $bits(tag_entry_t); i++) begin
			p[i % `ICACHE_TAG_PW] ^= bits[i];
		end
		return p;
	endfunction

endpackage

// ==== common/icache_tag_defs.svh ====
// sizing macros for the instruction cache tag subsystem
`ifndef ICACHE_TAG_DEFS_SVH
`define ICACHE_TAG_DEFS_SVH

//////////////////////////////////////////////////
// array geometry
//////////////////////////////////////////////////

`define ICACHE_TAG_AW 9	// set index bits, 512 sets

`define ICACHE_TAG_TW 12	// stored tag bits

`define ICACHE_TAG_WAYS 2	// ways per set

//////////////////////////////////////////////////
// protection
//////////////////////////////////////////////////

// interleaved check bits over the 15-bit payload
`define ICACHE_TAG_PW 4

`endif
